/* verilog.f */
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_branch_unit.sv
verilog/exec_multiplier.sv
verilog/execute.sv
verif/execute_checker.sv
verif/tb_execute.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_execute
FILELIST  := verilog.f
VFLAGS    := --binary --assert --timing -j 0
LINTFLAGS := --lint-only -Wall --timing --assert
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tb_execute.sv */
`timescale 1ns/1ps

module tb_execute;

    typedef struct packed {
        logic [exec_pkg::data_w-1:0] result;
        logic                        do_jump;
        logic [exec_pkg::data_w-1:0] j_addr;
    } expect_t;

    logic                        sys_clk;
    logic                        arst_n;
    exec_pkg::exe_ctrl_t         ctrl;
    exec_pkg::exe_operands_t     opnd;
    logic [exec_pkg::data_w-1:0] result;
    exec_pkg::exe_redirect_t     redirect;
    logic                        stall;

    int   checks;
    int   errors;
    int   timeouts;
    logic check_en;

    execute i_dut (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .opnd     (opnd),
        .result   (result),
        .redirect (redirect),
        .stall    (stall)
    );

    always #4 sys_clk = ~sys_clk;   // 8 ns period

    // expected outputs straight from the instruction rules
    function automatic expect_t ref_execute(input exec_pkg::exe_ctrl_t c,
                                            input exec_pkg::exe_operands_t o);
        expect_t            e;
        logic [31:0]        op2;
        logic [31:0]        alu;
        logic [4:0]         sh;
        logic [63:0]        prod;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic               taken;
        op2 = c.alu_src ? o.immd : o.reg2;
        sh  = c.shamt_var ? o.reg1[4:0] : c.ins_shamt;
        sa  = {{32{o.reg1[31]}}, o.reg1};
        sb  = {{32{o.reg2[31]}}, o.reg2};
        if (c.mul_unsigned) begin
            prod = {32'h0, o.reg1} * {32'h0, o.reg2};
        end else begin
            prod = sa * sb;
        end
        case (c.alu_op)
            exec_pkg::alu_add, exec_pkg::alu_addu: alu = o.reg1 + op2;
            exec_pkg::alu_sub, exec_pkg::alu_subu: alu = o.reg1 - op2;
            exec_pkg::alu_and:  alu = o.reg1 & op2;
            exec_pkg::alu_or:   alu = o.reg1 | op2;
            exec_pkg::alu_xor:  alu = o.reg1 ^ op2;
            exec_pkg::alu_nor:  alu = ~(o.reg1 | op2);
            exec_pkg::alu_lui:  alu = o.immd << 16;
            exec_pkg::alu_slt:  alu = {31'b0, $signed(o.reg1) < $signed(op2)};
            exec_pkg::alu_sltu: alu = {31'b0, o.reg1 < op2};
            exec_pkg::alu_sll:  alu = o.reg2 << sh;
            exec_pkg::alu_srl:  alu = o.reg2 >> sh;
            // logical shift and then fill the vacated top bits with the sign
            exec_pkg::alu_sra: begin
                alu = (o.reg2 >> sh) | (o.reg2[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            end
            default:            alu = 32'h0;
        endcase
        case (c.res_sel)
            exec_pkg::res_alu:    e.result = alu;
            exec_pkg::res_mul_lo: e.result = prod[31:0];
            exec_pkg::res_mul_hi: e.result = prod[63:32];
            exec_pkg::res_link:   e.result = o.next_pc + 32'd4;
            exec_pkg::res_bypass: e.result = o.bypass_immd;
            default:              e.result = 32'h0;
        endcase
        case (c.br_cond)
            exec_pkg::br_eq:     taken = o.reg1 == o.reg2;
            exec_pkg::br_ne:     taken = o.reg1 != o.reg2;
            exec_pkg::br_lez:    taken = $signed(o.reg1) <= 32'sd0;
            exec_pkg::br_gtz:    taken = $signed(o.reg1) > 32'sd0;
            exec_pkg::br_gez:    taken = $signed(o.reg1) >= 32'sd0;
            exec_pkg::br_always: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
        e.do_jump = 1'b1;
        if (c.jump_kind == exec_pkg::jmp_j) begin
            e.j_addr = {o.next_pc[31:28], c.ins_j_addr, 2'b00};
        end else if (c.jump_kind == exec_pkg::jmp_jr) begin
            e.j_addr = o.reg1;
        end else if (taken) begin
            e.j_addr = o.next_pc + (o.immd << 2);
        end else begin
            e.do_jump = 1'b0;
            e.j_addr  = 32'h0;
        end
        return e;
    endfunction

    function automatic exec_pkg::exe_ctrl_t make_ctrl(input exec_pkg::exe_alu_op_e op,
                                                      input exec_pkg::exe_res_sel_e sel);
        exec_pkg::exe_ctrl_t c;
        c           = '0;
        c.alu_op    = op;
        c.res_sel   = sel;
        c.br_cond   = exec_pkg::br_none;
        c.jump_kind = exec_pkg::jmp_none;
        return c;
    endfunction

    function automatic exec_pkg::exe_operands_t random_opnd();
        exec_pkg::exe_operands_t o;
        logic [31:0]             r;
        r             = $urandom();
        o.reg1        = $urandom();
        o.reg2        = $urandom();
        o.immd        = {{16{r[15]}}, r[15:0]};  // sign extended like the decoder
        o.next_pc     = $urandom() & 32'hffff_fffc;
        o.bypass_immd = $urandom();
        return o;
    endfunction

    task automatic compare_outputs();
        expect_t e;
        e = ref_execute(ctrl, opnd);
        checks++;
        if (redirect.do_jump !== e.do_jump) begin
            $display("ERR do_jump got %h exp %h", redirect.do_jump, e.do_jump);
            errors++;
        end
        if (redirect.j_addr !== e.j_addr) begin
            $display("ERR j_addr got %h exp %h", redirect.j_addr, e.j_addr);
            errors++;
        end
        // partial product on the port while stalled
        if (stall === 1'b0 && result !== e.result) begin
            $display("ERR result got %h exp %h", result, e.result);
            errors++;
        end
    endtask

    // compare once per cycle just before the next edge
    always begin
        @(posedge sys_clk);
        #7;
        if (check_en) begin
            compare_outputs();
        end
    end

    task automatic apply_comb(input exec_pkg::exe_ctrl_t c, input exec_pkg::exe_operands_t o);
        @(posedge sys_clk);
        #1;
        ctrl = c;
        opnd = o;
        #6;
        checks++;
        if (stall !== 1'b0) begin
            $display("ERR stall got %h exp %h", stall, 1'b0);
            errors++;
        end
    endtask

    task automatic run_mul(input exec_pkg::exe_ctrl_t c, input exec_pkg::exe_operands_t o);
        int cycles;
        @(posedge sys_clk);
        #1;
        ctrl = c;
        opnd = o;
        #6;
        cycles = 0;
        while (stall === 1'b1 && cycles < 40) begin
            cycles++;
            @(posedge sys_clk);
            #7;
        end
        if (stall !== 1'b0) begin
            $display("timeout: stall still high after %0d cycles of a multiply", cycles);
            timeouts++;
        end else begin
            checks++;
            if (cycles != exec_pkg::mul_cycles + 1) begin
                $display("ERR stall_cycles got %h exp %h", cycles, exec_pkg::mul_cycles + 1);
                errors++;
            end
        end
    endtask

    initial begin
        exec_pkg::exe_ctrl_t     c;
        exec_pkg::exe_operands_t o;
        logic [31:0]             edge_vals [5];
        logic [31:0]             br_vals [4];
        logic [31:0]             mul_a [5];
        logic [31:0]             mul_b [5];
        int                      sh_vals [4];
        void'($urandom(32'hec8a));
        edge_vals = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        br_vals   = '{32'h0, 32'h8000_0004, 32'h7, 32'hffff_ffff};
        mul_a     = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0, 32'h1};
        mul_b     = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff};
        sh_vals   = '{0, 1, 15, 31};
        sys_clk   = 1'b0;
        arst_n    = 1'b0;
        check_en  = 1'b0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        ctrl      = make_ctrl(exec_pkg::alu_add, exec_pkg::res_alu);
        opnd      = '0;
        repeat (2) @(posedge sys_clk);
        #1;
        arst_n   = 1'b1;
        check_en = 1'b1;

        // every alu op with both operand sources plus some link and bypass
        for (int op = 0; op < 14; op++) begin
            for (int src = 0; src < 2; src++) begin
                for (int rep = 0; rep < 6; rep++) begin
                    c = make_ctrl(exec_pkg::exe_alu_op_e'(4'(op)),
                                  rep == 4 ? exec_pkg::res_link :
                                  rep == 5 ? exec_pkg::res_bypass : exec_pkg::res_alu);
                    c.alu_src   = src[0];
                    c.shamt_var = 1'($urandom());
                    c.ins_shamt = 5'($urandom());
                    apply_comb(c, random_opnd());
                end
            end
        end

        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int u = 0; u < 2; u++) begin
                    c = make_ctrl(u == 0 ? exec_pkg::alu_slt : exec_pkg::alu_sltu,
                                  exec_pkg::res_alu);
                    o = random_opnd();
                    o.reg1 = edge_vals[i];
                    o.reg2 = edge_vals[j];
                    apply_comb(c, o);
                end
            end
        end

        for (int op = 0; op < 3; op++) begin
            for (int s = 0; s < 4; s++) begin
                for (int v = 0; v < 2; v++) begin
                    c = make_ctrl(op == 0 ? exec_pkg::alu_sll :
                                  op == 1 ? exec_pkg::alu_srl : exec_pkg::alu_sra,
                                  exec_pkg::res_alu);
                    c.shamt_var = v[0];
                    o = random_opnd();
                    if (v == 1) begin
                        o.reg1[4:0] = 5'(sh_vals[s]);
                        c.ins_shamt = 5'($urandom());   // must be ignored
                    end else begin
                        c.ins_shamt = 5'(sh_vals[s]);
                    end
                    o.reg2[31] = s[0];  // both fill values for sra
                    apply_comb(c, o);
                end
            end
        end

        for (int cond = 0; cond < 7; cond++) begin
            for (int k = 0; k < 4; k++) begin
                for (int same = 0; same < 2; same++) begin
                    c = make_ctrl(exec_pkg::alu_add, exec_pkg::res_alu);
                    c.br_cond = exec_pkg::exe_br_cond_e'(cond[2:0]);
                    o = random_opnd();
                    o.reg1 = br_vals[k];
                    o.reg2 = same == 1 ? br_vals[k] : br_vals[k] + 32'd1;
                    apply_comb(c, o);
                end
            end
        end
        for (int rep = 0; rep < 8; rep++) begin
            c = make_ctrl(exec_pkg::alu_add, exec_pkg::res_link);
            c.jump_kind  = rep[0] ? exec_pkg::jmp_jr : exec_pkg::jmp_j;
            c.br_cond    = exec_pkg::exe_br_cond_e'(3'(rep % 7));
            c.ins_j_addr = 26'($urandom());
            apply_comb(c, random_opnd());
        end

        for (int p = 0; p < 9; p++) begin
            for (int u = 0; u < 2; u++) begin
                for (int h = 0; h < 2; h++) begin
                    c = make_ctrl(exec_pkg::alu_add,
                                  h == 0 ? exec_pkg::res_mul_lo : exec_pkg::res_mul_hi);
                    c.mul_unsigned = u[0];
                    o = random_opnd();
                    if (p < 5) begin
                        o.reg1 = mul_a[p];
                        o.reg2 = mul_b[p];
                    end
                    run_mul(c, o);
                end
            end
        end

        // drop a multiply halfway and then run a full one
        c = make_ctrl(exec_pkg::alu_add, exec_pkg::res_mul_hi);
        @(posedge sys_clk);
        #1;
        ctrl = c;
        opnd = random_opnd();
        repeat (exec_pkg::mul_cycles / 2) @(posedge sys_clk);
        apply_comb(make_ctrl(exec_pkg::alu_xor, exec_pkg::res_alu), random_opnd());
        c.mul_unsigned = 1'b1;
        run_mul(c, random_opnd());

        @(posedge sys_clk);
        #1;
        check_en = 1'b0;
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verif/execute_checker.sv */
`timescale 1ns/1ps

module execute_checker (
    input logic                    sys_clk,
    input logic                    arst_n,
    input exec_pkg::exe_ctrl_t     ctrl,
    input exec_pkg::exe_redirect_t redirect,
    input logic                    stall
);

    int unsigned stall_run;    // consecutive stall cycles so far
    logic        mul_sel;

    assign mul_sel = (ctrl.res_sel == exec_pkg::res_mul_lo)
                  || (ctrl.res_sel == exec_pkg::res_mul_hi);

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_run <= 0;
        end else if (stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    a_reset_no_stall: assert property (@(posedge sys_clk) !arst_n |-> !stall)
        else $error("stall high during reset");

    a_idle_target_zero: assert property (@(posedge sys_clk) disable iff (!arst_n)
        !redirect.do_jump |-> redirect.j_addr == '0)
        else $error("j_addr not zero without a jump");

    // at most mul_cycles+1 stall cycles in a row
    a_stall_bounded: assert property (@(posedge sys_clk) disable iff (!arst_n)
        stall |-> stall_run <= exec_pkg::mul_cycles)
        else $error("stall held longer than one multiply");

    a_stall_only_mul: assert property (@(posedge sys_clk) disable iff (!arst_n)
        !mul_sel |-> !stall)
        else $error("stall raised for a non-multiply result");

endmodule

bind execute execute_checker u_checker (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl),
    .redirect (redirect),
    .stall    (stall)
);

/* verilog/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                        sys_clk,
    input  logic                        arst_n,
    input  exec_pkg::exe_ctrl_t         ctrl,
    input  exec_pkg::exe_operands_t     opnd,
    output logic [exec_pkg::data_w-1:0] result,
    output exec_pkg::exe_redirect_t     redirect,
    output logic                        stall
);

    logic [exec_pkg::data_w-1:0]   alu_result;
    logic [2*exec_pkg::data_w-1:0] product;
    logic                          mul_en;
    logic                          mul_done;

    exec_alu u_alu (
        .ctrl       (ctrl),
        .opnd       (opnd),
        .alu_result (alu_result)
    );

    exec_branch_unit u_branch (
        .ctrl     (ctrl),
        .opnd     (opnd),
        .redirect (redirect)
    );

    // either half keeps the multiplier running
    assign mul_en = (ctrl.res_sel == exec_pkg::res_mul_lo)
                 || (ctrl.res_sel == exec_pkg::res_mul_hi);

    exec_multiplier u_mul (
        .sys_clk      (sys_clk),
        .arst_n       (arst_n),
        .mul_en       (mul_en),
        .mul_unsigned (ctrl.mul_unsigned),
        .a            (opnd.reg1),
        .b            (opnd.reg2),
        .product      (product),
        .done         (mul_done)
    );

    // hold the pipe until the product is out
    assign stall = mul_en && !mul_done;

    always_comb begin
        case (ctrl.res_sel)
            exec_pkg::res_alu: begin
                result = alu_result;
            end
            exec_pkg::res_mul_lo: begin
                result = product[exec_pkg::data_w-1:0];
            end
            exec_pkg::res_mul_hi: begin
                result = product[2*exec_pkg::data_w-1:exec_pkg::data_w];
            end
            exec_pkg::res_link: begin
                // skip the delay slot
                result = opnd.next_pc + exec_pkg::data_w'(4);
            end
            exec_pkg::res_bypass: begin
                result = opnd.bypass_immd;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* verilog/exec_multiplier.sv */
`timescale 1ns/1ps

module exec_multiplier (
    input  logic                          sys_clk,
    input  logic                          arst_n,
    input  logic                          mul_en,
    input  logic                          mul_unsigned,
    input  logic [exec_pkg::data_w-1:0]   a,
    input  logic [exec_pkg::data_w-1:0]   b,
    output logic [2*exec_pkg::data_w-1:0] product,
    output logic                          done
);

    typedef enum logic [1:0] {
        idle,
        busy,
        finish
    } mul_state_e;

    mul_state_e                                 state;
    logic [$clog2(exec_pkg::mul_cycles)-1:0]    iter_cnt;
    logic                                       neg_res;
    logic                                       start;
    logic                                       last_iter;
    logic [exec_pkg::data_w-1:0]                a_mag;
    logic [exec_pkg::data_w-1:0]                b_mag;
    logic [exec_pkg::data_w-1:0]                mcand;
    logic [2*exec_pkg::data_w-1:0]              acc;    // {partial, multiplier}
    logic [exec_pkg::data_w:0]                  part_sum;

    assign start     = (state == idle) && mul_en;
    assign last_iter = int'(iter_cnt) == exec_pkg::mul_cycles - 1;

    // work on magnitudes, fix the sign at the end
    assign a_mag = (!mul_unsigned && a[exec_pkg::data_w-1]) ? -a : a;
    assign b_mag = (!mul_unsigned && b[exec_pkg::data_w-1]) ? -b : b;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            iter_cnt <= '0;
            neg_res  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (mul_en) begin
                        state    <= busy;
                        iter_cnt <= '0;
                        neg_res  <= !mul_unsigned
                                    && (a[exec_pkg::data_w-1] ^ b[exec_pkg::data_w-1]);
                    end
                end
                busy: begin
                    if (!mul_en) begin
                        state <= idle;      // aborted by upstream
                    end else if (last_iter) begin
                        state <= finish;
                    end
                    iter_cnt <= iter_cnt + 1'b1;
                end
                default: begin
                    state <= idle;          // one cycle of done
                end
            endcase
        end
    end

    // add multiplicand on a set lsb, then shift right
    assign part_sum = {1'b0, acc[2*exec_pkg::data_w-1:exec_pkg::data_w]}
                    + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge sys_clk) begin
        if (start) begin
            acc   <= {{exec_pkg::data_w{1'b0}}, b_mag};
            mcand <= a_mag;
        end else if (state == busy) begin
            acc <= {part_sum, acc[exec_pkg::data_w-1:1]};
        end
    end

    assign product = neg_res ? -acc : acc;
    assign done    = state == finish;

endmodule

/* verilog/exec_branch_unit.sv */
`timescale 1ns/1ps

module exec_branch_unit (
    input  exec_pkg::exe_ctrl_t     ctrl,
    input  exec_pkg::exe_operands_t opnd,
    output exec_pkg::exe_redirect_t redirect
);

    logic                        do_branch;
    logic [exec_pkg::data_w-1:0] jump_target;
    logic [exec_pkg::data_w-1:0] branch_target;

    // branch conditions on rs, rt
    always_comb begin
        case (ctrl.br_cond)
            exec_pkg::br_eq:     do_branch = opnd.reg1 == opnd.reg2;
            exec_pkg::br_ne:     do_branch = opnd.reg1 != opnd.reg2;
            exec_pkg::br_lez: begin
                do_branch = (opnd.reg1 == '0) || opnd.reg1[exec_pkg::data_w-1];
            end
            exec_pkg::br_gtz:    do_branch = $signed(opnd.reg1) > 0;
            exec_pkg::br_gez:    do_branch = !opnd.reg1[exec_pkg::data_w-1];
            exec_pkg::br_always: do_branch = 1'b1;
            default:             do_branch = 1'b0;
        endcase
    end

    // pc region bits kept, word index from the instruction
    assign jump_target = {opnd.next_pc[exec_pkg::data_w-1:28], ctrl.ins_j_addr, 2'b00};

    // word offset relative to the delay slot
    assign branch_target = opnd.next_pc + {opnd.immd[exec_pkg::data_w-3:0], 2'b00};

    always_comb begin
        case (ctrl.jump_kind)
            exec_pkg::jmp_j: begin
                redirect.do_jump = 1'b1;
                redirect.j_addr  = jump_target;
            end
            exec_pkg::jmp_jr: begin
                redirect.do_jump = 1'b1;
                redirect.j_addr  = opnd.reg1;
            end
            default: begin
                redirect.do_jump = do_branch;
                redirect.j_addr  = do_branch ? branch_target : '0;  // zero when not taken
            end
        endcase
    end

endmodule

/* verilog/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::exe_ctrl_t         ctrl,
    input  exec_pkg::exe_operands_t     opnd,
    output logic [exec_pkg::data_w-1:0] alu_result
);

    logic [exec_pkg::data_w-1:0] op2;
    logic [exec_pkg::data_w-1:0] addend;
    logic [exec_pkg::data_w-1:0] sum;
    logic                        is_sub;
    logic                        carry;
    logic                        sign_f;
    logic                        ovf_f;
    logic                        slt_bit;
    logic                        sltu_bit;
    logic [4:0]                  shamt;
    logic [exec_pkg::data_w-1:0] shift_out;

    assign op2 = ctrl.alu_src ? opnd.immd : opnd.reg2;

    // set-less-than reuses the subtractor
    always_comb begin
        case (ctrl.alu_op)
            exec_pkg::alu_sub,
            exec_pkg::alu_subu,
            exec_pkg::alu_slt,
            exec_pkg::alu_sltu: is_sub = 1'b1;
            default:            is_sub = 1'b0;
        endcase
    end

    // two's complement as inverted operand plus carry in
    assign addend = is_sub ? ~op2 : op2;
    assign {carry, sum} = {1'b0, opnd.reg1} + {1'b0, addend}
                        + {{exec_pkg::data_w{1'b0}}, is_sub};

    assign sign_f = sum[exec_pkg::data_w-1];

    // operands of equal sign giving a result of the other sign
    assign ovf_f = (opnd.reg1[exec_pkg::data_w-1] == addend[exec_pkg::data_w-1])
                 && (sum[exec_pkg::data_w-1] != opnd.reg1[exec_pkg::data_w-1]);

    assign slt_bit  = sign_f ^ ovf_f;
    assign sltu_bit = ~carry;   // borrow out

    assign shamt = ctrl.shamt_var ? opnd.reg1[4:0] : ctrl.ins_shamt;

    // shifter works on rt only
    always_comb begin
        case (ctrl.alu_op)
            exec_pkg::alu_sll: shift_out = opnd.reg2 << shamt;
            exec_pkg::alu_srl: shift_out = opnd.reg2 >> shamt;
            exec_pkg::alu_sra: shift_out = $signed(opnd.reg2) >>> shamt;  // sign fill
            default:           shift_out = '0;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            exec_pkg::alu_add,
            exec_pkg::alu_addu,
            exec_pkg::alu_sub,
            exec_pkg::alu_subu: begin
                alu_result = sum;   // no trap on overflow
            end
            exec_pkg::alu_and: begin
                alu_result = opnd.reg1 & op2;
            end
            exec_pkg::alu_or: begin
                alu_result = opnd.reg1 | op2;
            end
            exec_pkg::alu_xor: begin
                alu_result = opnd.reg1 ^ op2;
            end
            exec_pkg::alu_nor: begin
                alu_result = ~(opnd.reg1 | op2);
            end
            exec_pkg::alu_lui: begin
                alu_result = {opnd.immd[15:0], 16'h0000};
            end
            exec_pkg::alu_slt: begin
                alu_result = {{(exec_pkg::data_w-1){1'b0}}, slt_bit};
            end
            exec_pkg::alu_sltu: begin
                alu_result = {{(exec_pkg::data_w-1){1'b0}}, sltu_bit};
            end
            exec_pkg::alu_sll,
            exec_pkg::alu_srl,
            exec_pkg::alu_sra: begin
                alu_result = shift_out;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

/* verilog/exec_pkg.sv */
package exec_pkg;

    // datapath width, one machine word
    localparam int data_w = 32;

    // shift-add steps per multiply, one operand bit each
    localparam int mul_cycles = 32;

    // alu operations, as handed over by the decoder
    typedef enum logic [3:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_lui,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } exe_alu_op_e;

    // which unit feeds the stage result
    typedef enum logic [2:0] {
        res_alu,
        res_mul_lo,
        res_mul_hi,
        res_link,   // return address past the delay slot
        res_bypass  // immediate prepared upstream
    } exe_res_sel_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lez,
        br_gtz,
        br_gez,
        br_always   // bal
    } exe_br_cond_e;

    typedef enum logic [1:0] {
        jmp_none,
        jmp_j,      // j and jal, pc region plus index
        jmp_jr      // register target
    } exe_jump_e;

    // decoded control for one instruction
    typedef struct packed {
        exe_alu_op_e  alu_op;
        logic         alu_src;      // 0 reg2, 1 immd
        logic         shamt_var;    // shift by reg1[4:0]
        logic [4:0]   ins_shamt;
        exe_res_sel_e res_sel;
        logic         mul_unsigned;
        exe_br_cond_e br_cond;
        exe_jump_e    jump_kind;
        logic [25:0]  ins_j_addr;
    } exe_ctrl_t;

    // operand words from the register read stage
    typedef struct packed {
        logic [data_w-1:0] reg1;    // rs
        logic [data_w-1:0] reg2;    // rt
        logic [data_w-1:0] immd;    // sign extended upstream
        logic [data_w-1:0] next_pc;
        logic [data_w-1:0] bypass_immd;
    } exe_operands_t;

    // pc redirect towards fetch
    typedef struct packed {
        logic              do_jump;
        logic [data_w-1:0] j_addr;
    } exe_redirect_t;

endpackage
